// File: filelist.f
pp_pkg.sv
pp_bank_if.sv
dual_port_bram.sv
pp_buffer_west.sv
pp_buffer_north.sv
ping_pong_ctrl.sv
pp_subsystem_top.sv
tb_pp_subsystem.sv

// File: Bender.yml
package:
  name: pp_subsystem

sources:
  - pp_pkg.sv
  - pp_bank_if.sv
  - dual_port_bram.sv
  - pp_buffer_west.sv
  - pp_buffer_north.sv
  - ping_pong_ctrl.sv
  - pp_subsystem_top.sv
  - target: test
    files:
      - tb_pp_subsystem.sv

// File: tb_pp_subsystem.sv
// Testbench for the double-buffered operand store
// Random host fills and a random systolic array model; every read is
// checked against a reference image of the fill held in the read bank
module tb_pp_subsystem
    import pp_pkg::*;
();

    localparam int NUM_FILLS       = 6;
    localparam int CYCLES_PER_FILL = 400;
    localparam int TIMEOUT_CYCLES  = NUM_FILLS * CYCLES_PER_FILL;

    // One bank's content with entry a at bits a*SLICE_WIDTH upward
    typedef logic [(2**ADDR_WIDTH)*SLICE_WIDTH-1:0] image_t;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    word_t  w_word;
    word_t  n_word;
    logic   systolic_finish;
    logic   acc_done;
    logic   in_ready;
    logic   enable_matmul;
    logic   rd_valid;
    slice_t w_row0_slice;
    slice_t w_row1_slice;
    slice_t n_slice;

    // Complete fills not yet released by the array with the oldest first
    image_t west_q[$];
    image_t north_q[$];
    // Pending reads as due cycle and expected {row0, row1, north}
    int                       due_q[$];
    logic [3*SLICE_WIDTH-1:0] exp_q[$];
    logic [3*SLICE_WIDTH-1:0] exp_now;
    int                       due_now;

    int cyc = 0;

    pp_subsystem_top u_pp_subsystem_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .w_word          (w_word),
        .n_word          (n_word),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .in_ready        (in_ready),
        .enable_matmul   (enable_matmul),
        .rd_valid        (rd_valid),
        .w_row0_slice    (w_row0_slice),
        .w_row1_slice    (w_row1_slice),
        .n_slice         (n_slice)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Inputs change 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            report_failure("timeout, not all fills were read back");
        end
    end

    // Read results sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_valid) begin
                if (due_q.size() == 0) begin
                    report_failure("rd_valid without a systolic_finish two cycles earlier");
                end else begin
                    due_now = due_q.pop_front();
                    exp_now = exp_q.pop_front();
                    check_value("rd_valid cycle", cyc, due_now);
                    check_value("w_row0_slice", w_row0_slice,
                                exp_now[2*SLICE_WIDTH +: SLICE_WIDTH]);
                    check_value("w_row1_slice", w_row1_slice,
                                exp_now[SLICE_WIDTH +: SLICE_WIDTH]);
                    check_value("n_slice", n_slice, exp_now[0 +: SLICE_WIDTH]);
                end
            end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                report_failure("no rd_valid two cycles after a systolic_finish");
            end
            // Back-pressure while a full bank waits on an unreleased read bank
            if (west_q.size() == 2) begin
                check_value("in_ready", in_ready, 0);
            end
        end
    end

    // Host side sends one fill of FILL_BEATS beats
    task automatic send_fill();
        image_t wimg;
        image_t nimg;
        word_t  wv;
        word_t  nv;
        int     b;
        int     k;
        for (b = 0; b < FILL_BEATS; b++) begin
            repeat ($urandom_range(0, 2)) next_cycle();
            while (!in_ready) next_cycle();
            wv       = $urandom();
            nv       = $urandom();
            in_valid = 1'b1;
            w_word   = wv;
            n_word   = nv;
            // Slice k of beat b lands at entry 4*b + k
            for (k = 0; k < TOTAL_MODULES; k++) begin
                wimg[(TOTAL_MODULES*b+k)*SLICE_WIDTH +: SLICE_WIDTH] =
                    wv[k*SLICE_WIDTH +: SLICE_WIDTH];
                nimg[(TOTAL_MODULES*b+k)*SLICE_WIDTH +: SLICE_WIDTH] =
                    nv[k*SLICE_WIDTH +: SLICE_WIDTH];
            end
            next_cycle();
            in_valid = 1'b0;
        end
        west_q.push_back(wimg);
        north_q.push_back(nimg);
    endtask

    // Stray pulses while the array is idle must be ignored
    task automatic wait_for_enable();
        while (!enable_matmul) begin
            systolic_finish = ($urandom_range(0, 3) == 0);
            next_cycle();
        end
        systolic_finish = 1'b0;
        if (west_q.size() == 0) begin
            report_failure("enable_matmul rose with no complete fill written");
        end
    endtask

    // Random step pulses with back-to-back pulses allowed
    task automatic read_column(input int col);
        image_t wimg;
        image_t nimg;
        int     steps;
        steps = 0;
        wimg  = west_q[0];
        nimg  = north_q[0];
        while (steps < INNER_BLOCKS) begin
            check_value("enable_matmul", enable_matmul, 1);
            if ($urandom_range(0, 2) != 0) begin
                systolic_finish = 1'b1;
                due_q.push_back(cyc + 2);
                exp_q.push_back({wimg[steps*SLICE_WIDTH +: SLICE_WIDTH],
                                 wimg[(INNER_BLOCKS+steps)*SLICE_WIDTH +: SLICE_WIDTH],
                                 nimg[(INNER_BLOCKS*col+steps)*SLICE_WIDTH +: SLICE_WIDTH]});
                steps++;
            end else begin
                systolic_finish = 1'b0;
            end
            next_cycle();
        end
        systolic_finish = 1'b0;
    endtask

    // acc_done stays high for 1 to 3 cycles and its rising edge ends the column
    task automatic finish_column(input bit last);
        int hold;
        hold     = $urandom_range(1, 3);
        acc_done = 1'b1;
        next_cycle();
        if (last) begin
            check_value("enable_matmul", enable_matmul, 0);
            void'(west_q.pop_front());
            void'(north_q.pop_front());
            // This pulse must be ignored since the read bank is released
            systolic_finish = ($urandom_range(0, 1) == 1);
        end else begin
            check_value("enable_matmul", enable_matmul, 1);
        end
        acc_done = (hold > 1);
        next_cycle();
        systolic_finish = 1'b0;
        acc_done        = (hold > 2);
        next_cycle();
        acc_done = 1'b0;
    endtask

    task automatic send_all_fills();
        repeat (NUM_FILLS) send_fill();
    endtask

    task automatic read_all_fills();
        int c;
        repeat (NUM_FILLS) begin
            wait_for_enable();
            for (c = 0; c < COL_Y; c++) begin
                read_column(c);
                finish_column(c == COL_Y - 1);
            end
        end
    endtask

    initial begin
        void'($urandom(2));
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        w_word          = '0;
        n_word          = '0;
        systolic_finish = 1'b0;
        acc_done        = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // First cycle out of reset
        check_value("in_ready", in_ready, 0);
        check_value("enable_matmul", enable_matmul, 0);
        check_value("rd_valid", rd_valid, 0);
        next_cycle();
        check_value("in_ready", in_ready, 1);
        check_value("enable_matmul", enable_matmul, 0);
        fork
            send_all_fills();
            read_all_fills();
        join
        while (due_q.size() != 0) next_cycle();
        next_cycle();
        check_value("enable_matmul", enable_matmul, 0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: pp_subsystem_top.sv
// Double-buffered operand store in front of the systolic array
// Controller plus west and north ping-pong buffers, linked by four bank bundles
module pp_subsystem_top
    import pp_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  word_t  w_word,
    input  word_t  n_word,
    input  logic   systolic_finish,
    input  logic   acc_done,
    output logic   in_ready,
    output logic   enable_matmul,
    output logic   rd_valid,
    output slice_t w_row0_slice,
    output slice_t w_row1_slice,
    output slice_t n_slice
);

    slice_idx_t slicing_idx;
    logic       wr_en;
    logic       rd_bank;
    word_t      w_word_q;
    word_t      n_word_q;

    // One bundle per physical bank
    pp_bank_if w_bank0_if ();
    pp_bank_if w_bank1_if ();
    pp_bank_if n_bank0_if ();
    pp_bank_if n_bank1_if ();

    ping_pong_ctrl u_ping_pong_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .w_word          (w_word),
        .n_word          (n_word),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .in_ready        (in_ready),
        .enable_matmul   (enable_matmul),
        .rd_valid        (rd_valid),
        .slicing_idx     (slicing_idx),
        .wr_en           (wr_en),
        .rd_bank         (rd_bank),
        .w_word_q        (w_word_q),
        .n_word_q        (n_word_q),
        .w_bank0         (w_bank0_if.ctrl),
        .w_bank1         (w_bank1_if.ctrl),
        .n_bank0         (n_bank0_if.ctrl),
        .n_bank1         (n_bank1_if.ctrl)
    );

    pp_buffer_west u_pp_buffer_west (
        .clk          (clk),
        .w_word_q     (w_word_q),
        .slicing_idx  (slicing_idx),
        .wr_en        (wr_en),
        .rd_bank      (rd_bank),
        .bank0        (w_bank0_if.mem),
        .bank1        (w_bank1_if.mem),
        .w_row0_slice (w_row0_slice),
        .w_row1_slice (w_row1_slice)
    );

    pp_buffer_north u_pp_buffer_north (
        .clk         (clk),
        .n_word_q    (n_word_q),
        .slicing_idx (slicing_idx),
        .wr_en       (wr_en),
        .rd_bank     (rd_bank),
        .bank0       (n_bank0_if.mem),
        .bank1       (n_bank1_if.mem),
        .n_slice     (n_slice)
    );

endmodule

// File: ping_pong_ctrl.sv
// Ping-pong controller for the west and north operand buffers
// Slices each host beat into the write bank, generates read addresses
// for the systolic array and swaps banks when both sides are done
module ping_pong_ctrl
    import pp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  word_t      w_word,
    input  word_t      n_word,
    input  logic       systolic_finish,
    input  logic       acc_done,
    output logic       in_ready,
    output logic       enable_matmul,
    output logic       rd_valid,
    output slice_idx_t slicing_idx,
    output logic       wr_en,
    output logic       rd_bank,
    output word_t      w_word_q,
    output word_t      n_word_q,
    pp_bank_if.ctrl    w_bank0,
    pp_bank_if.ctrl    w_bank1,
    pp_bank_if.ctrl    n_bank0,
    pp_bank_if.ctrl    n_bank1
);

    ctrl_state_e state;
    ctrl_state_e state_n;

    // Bank roles, wr_bank is written, the other one is read
    logic       wr_bank;
    // Per bank, holds data not yet consumed by the array
    logic [1:0] loaded;

    logic [$clog2(FILL_BEATS)-1:0]   beat_cnt;
    logic [$clog2(INNER_BLOCKS)-1:0] step_cnt;
    logic [$clog2(COL_Y)-1:0]        col_cnt;

    logic  accept;
    logic  swap;
    logic  wr_row;
    addr_t wr_addr;

    // Read pipeline, address stage then data stage
    logic  rd_fire;
    logic  rd_en_q;
    addr_t w_rd_addr_a;
    addr_t w_rd_addr_b;
    addr_t n_rd_addr;

    logic  acc_done_d;
    logic  acc_rise;
    logic  col_adv;
    logic  rd_release;

    assign rd_bank       = ~wr_bank;
    assign enable_matmul = loaded[rd_bank];

    assign accept = (state == FILL_IDLE) && in_valid && in_ready;
    assign wr_en  = (state == FILL_SLICE);
    // Filled write bank moves over once the read bank is consumed
    assign swap   = (state == FILL_WAIT_SWAP) && !loaded[rd_bank];

    // Address 4*beat + slice; upper half of the west bank is row 1
    assign wr_addr = addr_t'({beat_cnt, slicing_idx});
    assign wr_row  = wr_addr[ADDR_WIDTH-1];

    always_comb begin
        state_n = state;
        case (state)
            FILL_IDLE: begin
                if (accept) begin
                    state_n = FILL_SLICE;
                end
            end
            FILL_SLICE: begin
                if (int'(slicing_idx) == TOTAL_MODULES - 1) begin
                    if (int'(beat_cnt) == FILL_BEATS - 1) begin
                        state_n = FILL_WAIT_SWAP;
                    end else begin
                        state_n = FILL_IDLE;
                    end
                end
            end
            FILL_WAIT_SWAP: begin
                if (swap) begin
                    state_n = FILL_IDLE;
                end
            end
            default: state_n = FILL_IDLE;
        endcase
    end

    // Fill side and bank roles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= FILL_IDLE;
            in_ready    <= 1'b0;
            slicing_idx <= '0;
            beat_cnt    <= '0;
            wr_bank     <= 1'b0;
            loaded      <= 2'b00;
        end else begin
            state    <= state_n;
            // Registered, so back-pressure holds through the whole wait
            in_ready <= (state_n == FILL_IDLE);
            if (state == FILL_SLICE) begin
                if (int'(slicing_idx) == TOTAL_MODULES - 1) begin
                    slicing_idx <= '0;
                    if (int'(beat_cnt) == FILL_BEATS - 1) begin
                        beat_cnt <= '0;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end else begin
                    slicing_idx <= slicing_idx + 1'b1;
                end
            end
            if (swap) begin
                wr_bank         <= ~wr_bank;
                loaded[wr_bank] <= 1'b1;
            end
            // Never in the same cycle as a swap, the read bank is loaded here
            if (rd_release) begin
                loaded[rd_bank] <= 1'b0;
            end
        end
    end

    // Hold the accepted beat for its slice cycles
    always_ff @(posedge clk) begin
        if (accept) begin
            w_word_q <= w_word;
            n_word_q <= n_word;
        end
    end

    assign rd_fire    = systolic_finish && enable_matmul;
    assign acc_rise   = acc_done && !acc_done_d;
    assign col_adv    = acc_rise && enable_matmul;
    assign rd_release = col_adv && (int'(col_cnt) == COL_Y - 1);

    // Read side counters and strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_en_q    <= 1'b0;
            rd_valid   <= 1'b0;
            step_cnt   <= '0;
            col_cnt    <= '0;
            acc_done_d <= 1'b0;
        end else begin
            acc_done_d <= acc_done;
            rd_en_q    <= rd_fire;
            rd_valid   <= rd_en_q;
            if (rd_fire) begin
                if (int'(step_cnt) == INNER_BLOCKS - 1) begin
                    step_cnt <= '0;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
            if (col_adv) begin
                if (int'(col_cnt) == COL_Y - 1) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // Step s of column c, row 0 at s, row 1 at 8 + s, north at 8*c + s
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            w_rd_addr_a <= addr_t'(step_cnt);
            w_rd_addr_b <= addr_t'(INNER_BLOCKS + int'(step_cnt));
            n_rd_addr   <= addr_t'(INNER_BLOCKS * int'(col_cnt) + int'(step_cnt));
        end
    end

    // West banks, row 0 written on port A, row 1 on port B
    assign w_bank0.wea   = wr_en && !wr_bank && !wr_row;
    assign w_bank0.web   = wr_en && !wr_bank && wr_row;
    assign w_bank0.ena   = (wr_en && !wr_bank && !wr_row) || (wr_bank && rd_en_q);
    assign w_bank0.enb   = (wr_en && !wr_bank && wr_row) || (wr_bank && rd_en_q);
    assign w_bank0.addra = wr_bank ? w_rd_addr_a : wr_addr;
    assign w_bank0.addrb = wr_bank ? w_rd_addr_b : wr_addr;

    assign w_bank1.wea   = wr_en && wr_bank && !wr_row;
    assign w_bank1.web   = wr_en && wr_bank && wr_row;
    assign w_bank1.ena   = (wr_en && wr_bank && !wr_row) || (!wr_bank && rd_en_q);
    assign w_bank1.enb   = (wr_en && wr_bank && wr_row) || (!wr_bank && rd_en_q);
    assign w_bank1.addra = wr_bank ? wr_addr : w_rd_addr_a;
    assign w_bank1.addrb = wr_bank ? wr_addr : w_rd_addr_b;

    // North banks, port A writes only, port B reads only
    assign n_bank0.wea   = wr_en && !wr_bank;
    assign n_bank0.web   = 1'b0;
    assign n_bank0.ena   = wr_en && !wr_bank;
    assign n_bank0.enb   = wr_bank && rd_en_q;
    assign n_bank0.addra = wr_addr;
    assign n_bank0.addrb = n_rd_addr;

    assign n_bank1.wea   = wr_en && wr_bank;
    assign n_bank1.web   = 1'b0;
    assign n_bank1.ena   = wr_en && wr_bank;
    assign n_bank1.enb   = !wr_bank && rd_en_q;
    assign n_bank1.addra = wr_addr;
    assign n_bank1.addrb = n_rd_addr;

    // Host may only present a beat while ready
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> in_ready)
        else $error("ping_pong_ctrl: in_valid while in_ready is low");

    // A slice write must never hit a bank still holding data for the array
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !loaded[wr_bank])
        else $error("ping_pong_ctrl: write into a bank that is being read");

endmodule

// File: pp_buffer_north.sv
// North (B-matrix) operand buffer
// Two banks; port A only writes, port B only reads
// Column c occupies addresses c*INNER_BLOCKS upward
module pp_buffer_north
    import pp_pkg::*;
(
    input  logic       clk,
    input  word_t      n_word_q,
    input  slice_idx_t slicing_idx,
    input  logic       wr_en,
    input  logic       rd_bank,
    pp_bank_if.mem     bank0,
    pp_bank_if.mem     bank1,
    output slice_t     n_slice
);

    slice_t wr_slice;
    slice_t doutb [2];
    logic   rd_bank_q;

    // Same slice order as the west buffer
    assign wr_slice = n_word_q[slicing_idx*SLICE_WIDTH +: SLICE_WIDTH];

    // Port B write strobe tied off, web from the bundle is not used
    dual_port_bram u_bank0 (
        .clk   (clk),
        .ena   (bank0.ena),
        .enb   (bank0.enb),
        .wea   (bank0.wea && wr_en),
        .web   (1'b0),
        .addra (bank0.addra),
        .addrb (bank0.addrb),
        .dina  (wr_slice),
        .dinb  (wr_slice),
        .douta (),
        .doutb (doutb[0])
    );

    dual_port_bram u_bank1 (
        .clk   (clk),
        .ena   (bank1.ena),
        .enb   (bank1.enb),
        .wea   (bank1.wea && wr_en),
        .web   (1'b0),
        .addra (bank1.addra),
        .addrb (bank1.addrb),
        .dina  (wr_slice),
        .dinb  (wr_slice),
        .douta (),
        .doutb (doutb[1])
    );

    // Bank select follows the read by one cycle
    always_ff @(posedge clk) begin
        rd_bank_q <= rd_bank;
    end

    assign n_slice = doutb[rd_bank_q];

    // Port B is the read port, the controller must never request a write on it
    assert property (@(posedge clk) !(bank0.web || bank1.web))
        else $error("pp_buffer_north: write requested on read port B");

endmodule

// File: pp_buffer_west.sv
// West (A-matrix) operand buffer
// Two banks; row 0 lives on port A, row 1 on port B
// Read data is selected by the bank that was addressed one cycle earlier
module pp_buffer_west
    import pp_pkg::*;
(
    input  logic       clk,
    input  word_t      w_word_q,
    input  slice_idx_t slicing_idx,
    input  logic       wr_en,
    input  logic       rd_bank,
    pp_bank_if.mem     bank0,
    pp_bank_if.mem     bank1,
    output slice_t     w_row0_slice,
    output slice_t     w_row1_slice
);

    slice_t wr_slice;
    slice_t douta [2];
    slice_t doutb [2];
    logic   rd_bank_q;

    // Slice k sits at bits k*SLICE_WIDTH upward
    assign wr_slice = w_word_q[slicing_idx*SLICE_WIDTH +: SLICE_WIDTH];

    // Writes only land in a slice cycle
    dual_port_bram u_bank0 (
        .clk   (clk),
        .ena   (bank0.ena),
        .enb   (bank0.enb),
        .wea   (bank0.wea && wr_en),
        .web   (bank0.web && wr_en),
        .addra (bank0.addra),
        .addrb (bank0.addrb),
        .dina  (wr_slice),
        .dinb  (wr_slice),
        .douta (douta[0]),
        .doutb (doutb[0])
    );

    dual_port_bram u_bank1 (
        .clk   (clk),
        .ena   (bank1.ena),
        .enb   (bank1.enb),
        .wea   (bank1.wea && wr_en),
        .web   (bank1.web && wr_en),
        .addra (bank1.addra),
        .addrb (bank1.addrb),
        .dina  (wr_slice),
        .dinb  (wr_slice),
        .douta (douta[1]),
        .doutb (doutb[1])
    );

    // Align the bank select with the registered RAM read
    always_ff @(posedge clk) begin
        rd_bank_q <= rd_bank;
    end

    assign w_row0_slice = douta[rd_bank_q];
    assign w_row1_slice = doutb[rd_bank_q];

endmodule

// File: dual_port_bram.sv
// True dual-port RAM, one slice per entry
// Each port writes or reads; reads are registered, write-first
module dual_port_bram
    import pp_pkg::*;
(
    input  logic   clk,
    input  logic   ena,
    input  logic   enb,
    input  logic   wea,
    input  logic   web,
    input  addr_t  addra,
    input  addr_t  addrb,
    input  slice_t dina,
    input  slice_t dinb,
    output slice_t douta,
    output slice_t doutb
);

    slice_t mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        // Port A
        if (ena) begin
            if (wea) begin
                mem[addra] <= dina;
                // Write-first, new data shows on the output
                douta      <= dina;
            end else begin
                douta <= mem[addra];
            end
        end
        // Port B
        if (enb) begin
            if (web) begin
                mem[addrb] <= dinb;
                doutb      <= dinb;
            end else begin
                doutb <= mem[addrb];
            end
        end
    end

    // Both ports writing one entry in the same cycle leaves it undefined
    assert property (@(posedge clk) (ena && wea && enb && web) |-> (addra != addrb))
        else $error("dual_port_bram: write collision at address %0d", addra);

endmodule

// File: pp_bank_if.sv
// Control bundle of one operand bank
// Carries enables, write strobes and addresses for both RAM ports
interface pp_bank_if
    import pp_pkg::*;
();

    // Port enables
    logic  ena;
    logic  enb;

    // Port write strobes
    logic  wea;
    logic  web;

    // Port addresses
    addr_t addra;
    addr_t addrb;

    // Controller side
    modport ctrl (
        output ena, enb, wea, web, addra, addrb
    );

    // Bank side
    modport mem (
        input  ena, enb, wea, web, addra, addrb
    );

endinterface

// File: pp_pkg.sv
// Operand store package
// Sizes, vector types and the fill FSM encoding shared by the
// ping-pong controller and the west/north operand buffers
package pp_pkg;

    // Slices per host word and bits per slice
    localparam int TOTAL_MODULES = 4;
    localparam int SLICE_WIDTH   = 8;

    // Bank depth, 16 entries
    localparam int ADDR_WIDTH    = 4;

    // Host beats needed to fill one bank
    localparam int FILL_BEATS    = 4;

    // Inner-dimension steps per output column
    // Also one west row region and one north column region
    localparam int INNER_BLOCKS  = 8;

    // Output columns held in one bank
    localparam int COL_Y         = 2;

    // One bank entry
    typedef logic [SLICE_WIDTH-1:0] slice_t;

    // Full host word, all slices side by side
    typedef logic [TOTAL_MODULES*SLICE_WIDTH-1:0] word_t;

    // Bank address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Slice position inside a word
    typedef logic [1:0] slice_idx_t;

    // Fill side FSM
    typedef enum logic [1:0] {
        FILL_IDLE,      // waiting for a host beat
        FILL_SLICE,     // writing the slices of the held beat
        FILL_WAIT_SWAP  // write bank full, waiting for the read bank
    } ctrl_state_e;

endpackage
